// File: logic/cpuPkg.sv
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [3:0] byteEn_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [1:0] fwdSel_t;

	// top address bits cleared on the data bus.
	localparam int ADDR_MASK_BITS = 3;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0D;
	localparam logic [5:0] OP_LUI = 6'h0F;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2B;

	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2A;

	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_AND = 4'd2;
	localparam aluOp_t ALU_OR = 4'd3;
	localparam aluOp_t ALU_SLT = 4'd4;
	localparam aluOp_t ALU_LUI = 4'd5;

	// execute operand sources.
	localparam fwdSel_t FWD_REG = 2'd0;
	localparam fwdSel_t FWD_MEM = 2'd1;
	localparam fwdSel_t FWD_WB = 2'd2;

endpackage

`default_nettype wire

// File: logic/pipeIf.sv
`default_nettype none

interface decExIf import cpuPkg::*; ();
	aluOp_t aluOp;
	logic aluSrcImm;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic regDst; // 1 selects rd.
	word_t rsVal;
	word_t rtVal;
	word_t imm;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t pc;

	modport source (
		output aluOp, aluSrcImm, regWrite, memRead, memWrite, regDst,
		output rsVal, rtVal, imm, rs, rt, rd, pc
	);
	modport sink (
		input aluOp, aluSrcImm, regWrite, memRead, memWrite, regDst,
		input rsVal, rtVal, imm, rs, rt, rd, pc
	);
endinterface

interface exMemIf import cpuPkg::*; ();
	logic regWrite;
	logic memRead;
	logic memWrite;
	word_t aluResult;
	word_t storeData;
	regAddr_t writeReg;
	word_t pc;

	modport source (output regWrite, memRead, memWrite, aluResult, storeData, writeReg, pc);
	modport sink (input regWrite, memRead, memWrite, aluResult, storeData, writeReg, pc);
	modport reader (input regWrite, memRead, writeReg, aluResult);
endinterface

interface hazardIf import cpuPkg::*; ();
	regAddr_t rsD;
	regAddr_t rtD;
	logic usesBranchD;
	regAddr_t rsE;
	regAddr_t rtE;
	regAddr_t writeRegE;
	logic regWriteE;
	logic memReadE;
	logic stallF;
	logic stallD;
	logic flushE;
	fwdSel_t fwdAE;
	fwdSel_t fwdBE;
	logic fwdAD; // branch operands only take the MEM path.
	logic fwdBD;

	modport decode (output rsD, rtD, usesBranchD, input stallD, flushE, fwdAD, fwdBD);
	modport execute (output rsE, rtE, writeRegE, regWriteE, memReadE, input fwdAE, fwdBE);
	modport unit (
		input rsD, rtD, usesBranchD, rsE, rtE, writeRegE, regWriteE, memReadE,
		output stallF, stallD, flushE, fwdAE, fwdBE, fwdAD, fwdBD
	);
endinterface

`default_nettype wire

// File: logic/fetchStage.sv
`default_nettype none

module fetchStage import cpuPkg::*; #(
	parameter word_t RESET_PC = 32'hBFC00000
) (
	input logic clk,
	input logic arstN_i,
	input logic stallF_i,
	input logic redirect_i,
	input word_t redirectTarget_i,
	output word_t instSramAddr_o,
	output word_t pcD_o
);
	word_t pc; // address requested this cycle.
	word_t pcNext;

	// a stalled decode asks for its own instruction again.
	assign instSramAddr_o = stallF_i ? pcD_o : pc;

	always_comb begin
		if (stallF_i) begin
			pcNext = pc;
		end else if (redirect_i) begin
			pcNext = redirectTarget_i; // delay slot is already in flight.
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			pc <= RESET_PC;
			pcD_o <= RESET_PC;
		end else begin
			pc <= pcNext;
			if (!stallF_i) pcD_o <= pc;
		end
	end

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
`default_nettype none

module decodeStage import cpuPkg::*; (
	input logic clk,
	input logic arstN_i,
	input word_t instr_i,
	input word_t pcD_i,
	input logic wbWe_i,
	input regAddr_t wbAddr_i,
	input word_t wbData_i,
	exMemIf.reader exMem,
	hazardIf.decode haz,
	decExIf.source idEx,
	output logic redirect_o,
	output word_t redirectTarget_o
);
	word_t rf [32];
	logic instValid;
	word_t instr;
	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rs, rt, rd;
	regAddr_t rsSrc, rtSrc;
	logic isBeq, isBne, isJ, usesRt;
	aluOp_t aluOp;
	logic aluSrcImm, regWrite, memRead, memWrite, regDst, zeroExt;
	word_t imm, rsVal, rtVal, pcPlus4;
	logic taken;

	function automatic word_t readReg(regAddr_t a);
		if (a == '0) return '0;
		if (wbWe_i && wbAddr_i == a) return wbData_i; // write-through.
		return rf[a];
	endfunction

	always_ff @(posedge clk) begin
		if (wbWe_i && wbAddr_i != '0) rf[wbAddr_i] <= wbData_i;
	end

	// SRAM data is stale until the first fetch has returned.
	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) instValid <= 1'b0;
		else instValid <= 1'b1;
	end

	assign instr = instValid ? instr_i : '0;
	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		aluOp = ALU_ADD;
		aluSrcImm = 1'b1;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regDst = 1'b0;
		zeroExt = 1'b0;
		usesRt = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJ = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				aluSrcImm = 1'b0;
				regDst = 1'b1;
				usesRt = 1'b1;
				regWrite = 1'b1;
				case (funct)
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_SLT: aluOp = ALU_SLT;
					default: regWrite = 1'b0; // anything else passes as a nop.
				endcase
			end
			OP_ADDIU: regWrite = 1'b1;
			OP_ORI: begin
				aluOp = ALU_OR;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			OP_LUI: begin
				aluOp = ALU_LUI;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			OP_LW: begin
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			OP_SW: begin
				memWrite = 1'b1;
				usesRt = 1'b1;
			end
			OP_BEQ: begin
				isBeq = 1'b1;
				usesRt = 1'b1;
			end
			OP_BNE: begin
				isBne = 1'b1;
				usesRt = 1'b1;
			end
			OP_J: isJ = 1'b1;
			default: ;
		endcase
	end

	// J carries target bits where rs would be.
	assign rsSrc = isJ ? '0 : rs;
	assign rtSrc = usesRt ? rt : '0;
	assign haz.rsD = rsSrc;
	assign haz.rtD = rtSrc;
	assign haz.usesBranchD = isBeq | isBne;

	assign rsVal = haz.fwdAD ? exMem.aluResult : readReg(rsSrc);
	assign rtVal = haz.fwdBD ? exMem.aluResult : readReg(rtSrc);
	assign imm = zeroExt ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign pcPlus4 = pcD_i + 32'd4;

	assign taken = isJ | (isBeq & (rsVal == rtVal)) | (isBne & (rsVal != rtVal));
	assign redirect_o = taken & ~haz.stallD;
	assign redirectTarget_o = isJ ? {pcPlus4[31:28], instr[25:0], 2'b00}
		: pcPlus4 + {imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			idEx.regWrite <= 1'b0;
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
		end else if (haz.flushE) begin
			idEx.regWrite <= 1'b0; // bubble.
			idEx.memRead <= 1'b0;
			idEx.memWrite <= 1'b0;
		end else if (!haz.stallD) begin
			idEx.regWrite <= regWrite;
			idEx.memRead <= memRead;
			idEx.memWrite <= memWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!haz.stallD) begin
			idEx.aluOp <= aluOp;
			idEx.aluSrcImm <= aluSrcImm;
			idEx.regDst <= regDst;
			idEx.rsVal <= rsVal;
			idEx.rtVal <= rtVal;
			idEx.imm <= imm;
			idEx.rs <= rsSrc;
			idEx.rt <= rt;
			idEx.rd <= rd;
			idEx.pc <= pcD_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/executeStage.sv
`default_nettype none

module executeStage import cpuPkg::*; (
	input logic clk,
	input logic arstN_i,
	decExIf.sink idEx,
	input word_t wbData_i,
	hazardIf.execute haz,
	exMemIf.source exMem
);
	word_t srcA;
	word_t srcB;
	word_t opB;
	word_t aluResult;
	regAddr_t writeReg;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal,
			word_t wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(haz.fwdAE, idEx.rsVal, exMem.aluResult, wbData_i);
	assign srcB = fwdMux(haz.fwdBE, idEx.rtVal, exMem.aluResult, wbData_i);
	assign opB = idEx.aluSrcImm ? idEx.imm : srcB;

	always_comb begin
		case (idEx.aluOp)
			ALU_ADD: aluResult = srcA + opB;
			ALU_SUB: aluResult = srcA - opB;
			ALU_AND: aluResult = srcA & opB;
			ALU_OR: aluResult = srcA | opB;
			ALU_SLT: aluResult = {31'h0, $signed(srcA) < $signed(opB)};
			ALU_LUI: aluResult = {opB[15:0], 16'h0};
			default: aluResult = '0;
		endcase
	end

	assign writeReg = idEx.regDst ? idEx.rd : idEx.rt;

	assign haz.rsE = idEx.rs;
	assign haz.rtE = idEx.rt;
	assign haz.writeRegE = writeReg;
	assign haz.regWriteE = idEx.regWrite;
	assign haz.memReadE = idEx.memRead;

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem.regWrite <= idEx.regWrite;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		exMem.aluResult <= aluResult;
		exMem.storeData <= srcB; // forwarded rt.
		exMem.writeReg <= writeReg;
		exMem.pc <= idEx.pc;
	end

endmodule

`default_nettype wire

// File: logic/memWbStage.sv
`default_nettype none

module memWbStage import cpuPkg::*; (
	input logic clk,
	input logic arstN_i,
	exMemIf.sink exMem,
	input word_t dataSramRdata_i,
	output byteEn_t dataSramWen_o,
	output word_t dataSramAddr_o,
	output word_t dataSramWdata_o,
	output logic wbWe_o,
	output regAddr_t wbAddr_o,
	output word_t wbData_o,
	output word_t debugWbPc_o,
	output byteEn_t debugWbRfWen_o,
	output regAddr_t debugWbRfWnum_o,
	output word_t debugWbRfWdata_o
);
	logic regWriteW;
	logic memReadW;
	word_t aluResultW;
	regAddr_t writeRegW;
	word_t pcW;

	// full-word stores only.
	assign dataSramWen_o = exMem.memWrite ? '1 : '0;
	assign dataSramAddr_o = {{ADDR_MASK_BITS{1'b0}}, exMem.aluResult[31-ADDR_MASK_BITS:0]};
	assign dataSramWdata_o = exMem.storeData;

	always_ff @(posedge clk or negedge arstN_i) begin
		if (!arstN_i) begin
			regWriteW <= 1'b0;
			memReadW <= 1'b0;
		end else begin
			regWriteW <= exMem.regWrite;
			memReadW <= exMem.memRead;
		end
	end

	always_ff @(posedge clk) begin
		aluResultW <= exMem.aluResult;
		writeRegW <= exMem.writeReg;
		pcW <= exMem.pc;
	end

	// load data lands here, one cycle after the request.
	assign wbData_o = memReadW ? dataSramRdata_i : aluResultW;
	assign wbWe_o = regWriteW;
	assign wbAddr_o = writeRegW;

	assign debugWbPc_o = pcW;
	assign debugWbRfWen_o = regWriteW ? '1 : '0; // r0 writes are traced too.
	assign debugWbRfWnum_o = writeRegW;
	assign debugWbRfWdata_o = wbData_o;

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`default_nettype none

module hazardUnit import cpuPkg::*; (
	hazardIf.unit haz,
	exMemIf.reader exMem,
	input logic wbWe_i,
	input regAddr_t wbAddr_i
);
	regAddr_t dstE; // destination per stage, zero when nothing is written.
	regAddr_t loadDstE;
	regAddr_t dstM;
	regAddr_t aluDstM;
	regAddr_t loadDstM;
	regAddr_t dstW;
	logic loadUse;
	logic branchStall;

	function automatic fwdSel_t fwdSelect(regAddr_t src, regAddr_t memDst, regAddr_t wbDst);
		if (src != '0 && src == memDst) return FWD_MEM; // newest value wins.
		if (src != '0 && src == wbDst) return FWD_WB;
		return FWD_REG;
	endfunction

	function automatic logic hits(regAddr_t dst, regAddr_t srcA, regAddr_t srcB);
		return dst != '0 && (dst == srcA || dst == srcB);
	endfunction

	assign dstE = haz.regWriteE ? haz.writeRegE : '0;
	assign loadDstE = haz.memReadE ? haz.writeRegE : '0;
	assign dstM = exMem.regWrite ? exMem.writeReg : '0;
	assign aluDstM = exMem.memRead ? '0 : dstM;
	assign loadDstM = exMem.memRead ? exMem.writeReg : '0;
	assign dstW = wbWe_i ? wbAddr_i : '0;

	assign haz.fwdAE = fwdSelect(haz.rsE, dstM, dstW);
	assign haz.fwdBE = fwdSelect(haz.rtE, dstM, dstW);

	// a load in MEM has only its address, so decode never takes it.
	assign haz.fwdAD = aluDstM != '0 && aluDstM == haz.rsD;
	assign haz.fwdBD = aluDstM != '0 && aluDstM == haz.rtD;

	assign loadUse = hits(loadDstE, haz.rsD, haz.rtD);
	assign branchStall = haz.usesBranchD
		&& (hits(dstE, haz.rsD, haz.rtD) || hits(loadDstM, haz.rsD, haz.rtD));

	assign haz.stallF = loadUse | branchStall;
	assign haz.stallD = loadUse | branchStall;
	assign haz.flushE = loadUse | branchStall;

endmodule

`default_nettype wire

// File: logic/mipsCore.sv
`default_nettype none

module mipsCore #(
	parameter cpuPkg::word_t RESET_PC = 32'hBFC00000
) (
	input logic clk,
	input logic arstN_i,
	input cpuPkg::word_t instSramRdata_i,
	input cpuPkg::word_t dataSramRdata_i,
	output logic instSramEn_o,
	output cpuPkg::byteEn_t instSramWen_o,
	output cpuPkg::word_t instSramAddr_o,
	output cpuPkg::word_t instSramWdata_o,
	output logic dataSramEn_o,
	output cpuPkg::byteEn_t dataSramWen_o,
	output cpuPkg::word_t dataSramAddr_o,
	output cpuPkg::word_t dataSramWdata_o,
	output cpuPkg::word_t debugWbPc_o,
	output cpuPkg::byteEn_t debugWbRfWen_o,
	output cpuPkg::regAddr_t debugWbRfWnum_o,
	output cpuPkg::word_t debugWbRfWdata_o
);
	cpuPkg::word_t pcD;
	logic redirect;
	cpuPkg::word_t redirectTarget;
	logic wbWe;
	cpuPkg::regAddr_t wbAddr;
	cpuPkg::word_t wbData;

	decExIf idEx ();
	exMemIf exMem ();
	hazardIf haz ();

	assign instSramEn_o = arstN_i; // fetch runs as soon as reset lifts.
	assign instSramWen_o = '0;
	assign instSramWdata_o = '0;
	assign dataSramEn_o = 1'b1;

	fetchStage #(.RESET_PC(RESET_PC)) i_fetchStage (
		.clk              (clk),
		.arstN_i          (arstN_i),
		.stallF_i         (haz.stallF),
		.redirect_i       (redirect),
		.redirectTarget_i (redirectTarget),
		.instSramAddr_o   (instSramAddr_o),
		.pcD_o            (pcD)
	);

	decodeStage i_decodeStage (
		.clk              (clk),
		.arstN_i          (arstN_i),
		.instr_i          (instSramRdata_i),
		.pcD_i            (pcD),
		.wbWe_i           (wbWe),
		.wbAddr_i         (wbAddr),
		.wbData_i         (wbData),
		.exMem            (exMem),
		.haz              (haz),
		.idEx             (idEx),
		.redirect_o       (redirect),
		.redirectTarget_o (redirectTarget)
	);

	executeStage i_executeStage (
		.clk      (clk),
		.arstN_i  (arstN_i),
		.idEx     (idEx),
		.wbData_i (wbData),
		.haz      (haz),
		.exMem    (exMem)
	);

	memWbStage i_memWbStage (
		.clk              (clk),
		.arstN_i          (arstN_i),
		.exMem            (exMem),
		.dataSramRdata_i  (dataSramRdata_i),
		.dataSramWen_o    (dataSramWen_o),
		.dataSramAddr_o   (dataSramAddr_o),
		.dataSramWdata_o  (dataSramWdata_o),
		.wbWe_o           (wbWe),
		.wbAddr_o         (wbAddr),
		.wbData_o         (wbData),
		.debugWbPc_o      (debugWbPc_o),
		.debugWbRfWen_o   (debugWbRfWen_o),
		.debugWbRfWnum_o  (debugWbRfWnum_o),
		.debugWbRfWdata_o (debugWbRfWdata_o)
	);

	hazardUnit i_hazardUnit (
		.haz      (haz),
		.exMem    (exMem),
		.wbWe_i   (wbWe),
		.wbAddr_i (wbAddr)
	);

endmodule

`default_nettype wire

// File: dv/tbMemModel.sv
`default_nettype none

module tbMemModel import cpuPkg::*; #(
	parameter word_t RESET_PC = 32'hBFC00000
) (
	input logic clk,
	input logic instEn_i,
	input word_t instAddr_i,
	output word_t instRdata_o,
	input byteEn_t dataWen_i,
	input word_t dataAddr_i,
	input word_t dataWdata_i,
	output word_t dataRdata_o,
	output int progLen_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam word_t DATA_BASE = 32'h0000_0100; // physical, after the top bits are cleared.

	word_t rom [128];
	word_t ram [64];
	word_t modelRam [64];
	int progLen = 0;
	word_t lcgState = 32'd81657;
	logic instEnQ = 1'b0;
	byteEn_t dataWenQ = '0;
	word_t instAddrQ;
	word_t dataAddrQ;
	word_t dataWdataQ;
	word_t expPc [$];
	regAddr_t expNum [$];
	word_t expData [$];
	word_t expStAddr [$];
	word_t expStData [$];

	assign progLen_o = progLen;

	function automatic word_t nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic logic [15:0] randImm();
		word_t v;
		v = nextRand();
		return v[30:15]; // low LCG bits repeat too quickly.
	endfunction

	function automatic word_t fillWord(word_t a);
		return {a[15:0], ~a[31:16]} ^ 32'h3C5A96E1;
	endfunction

	function automatic logic inWindow(word_t a);
		return a[31:8] == DATA_BASE[31:8];
	endfunction

	function automatic word_t rType(logic [5:0] fn, regAddr_t rs, regAddr_t rt, regAddr_t rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iType(logic [5:0] op, regAddr_t rs, regAddr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jType(word_t target);
		return {OP_J, target[27:2]};
	endfunction

	function automatic word_t romWord(word_t a);
		word_t off;
		off = a - RESET_PC;
		if (off[1:0] == 2'b00 && off < 4 * progLen) return rom[off[8:2]];
		return '0; // past the program the core only sees nops.
	endfunction

	task automatic emit(word_t ins);
		rom[progLen] = ins;
		progLen++;
	endtask

	task automatic buildProgram();
		for (int r = 1; r <= 6; r++) begin
			emit(iType(OP_LUI, 5'd0, regAddr_t'(r), randImm()));
			emit(iType(OP_ORI, regAddr_t'(r), regAddr_t'(r), randImm()));
		end
		// back-to-back dependent ALU chain.
		emit(rType(FN_ADDU, 5'd1, 5'd2, 5'd9));
		emit(rType(FN_SUBU, 5'd9, 5'd3, 5'd10));
		emit(rType(FN_AND, 5'd10, 5'd9, 5'd11));
		emit(rType(FN_OR, 5'd11, 5'd4, 5'd12));
		emit(rType(FN_SLT, 5'd12, 5'd5, 5'd13));
		emit(rType(FN_SLT, 5'd5, 5'd12, 5'd14));
		emit(iType(OP_ADDIU, 5'd13, 5'd14, randImm()));
		emit(iType(OP_ORI, 5'd14, 5'd15, randImm()));
		emit(iType(OP_ADDIU, 5'd15, 5'd15, randImm()));
		emit(iType(OP_LUI, 5'd0, 5'd20, 16'h8000)); // kseg0 base, lands on DATA_BASE.
		emit(iType(OP_ORI, 5'd20, 5'd20, 16'h0100));
		emit(iType(OP_SW, 5'd20, 5'd9, 16'h0000));
		emit(iType(OP_ADDIU, 5'd1, 5'd16, randImm()));
		emit(iType(OP_SW, 5'd20, 5'd16, 16'h0008)); // store data still in MEM.
		emit(iType(OP_SW, 5'd20, 5'd15, 16'h0004));
		emit(iType(OP_LW, 5'd20, 5'd17, 16'h0000));
		emit(rType(FN_ADDU, 5'd17, 5'd2, 5'd18)); // load-use.
		emit(iType(OP_LW, 5'd20, 5'd19, 16'h0008));
		emit(rType(FN_SUBU, 5'd19, 5'd17, 5'd21));
		emit(iType(OP_ADDIU, 5'd20, 5'd22, 16'h0008));
		emit(iType(OP_LW, 5'd22, 5'd23, 16'hFFFC));
		// taken BEQ whose operand is still in EX.
		emit(iType(OP_ADDIU, 5'd1, 5'd24, 16'h0000));
		emit(iType(OP_BEQ, 5'd24, 5'd1, 16'h0002));
		emit(iType(OP_ADDIU, 5'd0, 5'd25, randImm()));
		emit(iType(OP_ADDIU, 5'd0, 5'd26, 16'h0001));
		// not-taken BNE, operand from MEM.
		emit(iType(OP_ADDIU, 5'd2, 5'd27, 16'h0000));
		emit(rType(FN_OR, 5'd3, 5'd0, 5'd28));
		emit(iType(OP_BNE, 5'd27, 5'd2, 16'h0002));
		emit(rType(FN_ADDU, 5'd27, 5'd28, 5'd29));
		emit(iType(OP_ORI, 5'd0, 5'd26, randImm()));
		emit(iType(OP_LW, 5'd20, 5'd30, 16'h0004));
		emit(iType(OP_BNE, 5'd30, 5'd15, 16'h0002)); // waits two cycles for the load.
		emit(iType(OP_ADDIU, 5'd30, 5'd31, randImm()));
		emit(iType(OP_ADDIU, 5'd31, 5'd31, 16'h0001));
		emit(iType(OP_BEQ, 5'd1, 5'd2, 16'h0002));
		emit(iType(OP_ADDIU, 5'd3, 5'd24, randImm()));
		emit(iType(OP_ADDIU, 5'd24, 5'd25, randImm()));
		emit(iType(OP_BNE, 5'd3, 5'd0, 16'h0002));
		emit(iType(OP_ADDIU, 5'd4, 5'd26, randImm()));
		emit(iType(OP_ADDIU, 5'd0, 5'd27, 16'h0002));
		emit(jType(RESET_PC + 4 * (progLen + 3)));
		emit(rType(FN_SUBU, 5'd26, 5'd25, 5'd28));
		emit(iType(OP_ADDIU, 5'd0, 5'd29, 16'h0003));
		// r0 is written, then read right away.
		emit(iType(OP_ADDIU, 5'd1, 5'd0, randImm()));
		emit(rType(FN_ADDU, 5'd0, 5'd2, 5'd9));
		emit(rType(FN_OR, 5'd9, 5'd0, 5'd10));
	endtask

	// MIPS32 semantics with one delay slot per branch or jump.
	task automatic runModel();
		word_t regs [32];
		word_t pc, npc, target, slot, ins, a, b, imm, result, ea;
		regAddr_t dst;
		logic writes;
		int steps;
		foreach (regs[i]) regs[i] = '0;
		pc = RESET_PC;
		npc = RESET_PC + 32'd4;
		steps = 0;
		while ((pc - RESET_PC) < word_t'(4 * progLen) && steps < 1000) begin
			ins = rom[(pc - RESET_PC) >> 2];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			slot = pc + 32'd4;
			target = npc + 32'd4;
			dst = ins[20:16];
			writes = 1'b1;
			result = '0;
			case (ins[31:26])
				OP_RTYPE: begin
					dst = ins[15:11];
					case (ins[5:0])
						FN_ADDU: result = a + b;
						FN_SUBU: result = a - b;
						FN_AND: result = a & b;
						FN_OR: result = a | b;
						FN_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				OP_ADDIU: result = a + imm;
				OP_ORI: result = a | {16'h0, ins[15:0]};
				OP_LUI: result = {ins[15:0], 16'h0};
				OP_LW: begin
					ea = (a + imm) & 32'h1FFFFFFF;
					result = inWindow(ea) ? modelRam[ea[7:2]] : fillWord(ea);
				end
				OP_SW: begin
					ea = (a + imm) & 32'h1FFFFFFF;
					if (inWindow(ea)) modelRam[ea[7:2]] = b;
					expStAddr.push_back(ea);
					expStData.push_back(b);
					writes = 1'b0;
				end
				OP_BEQ: begin
					writes = 1'b0;
					if (a == b) target = slot + (imm << 2);
				end
				OP_BNE: begin
					writes = 1'b0;
					if (a != b) target = slot + (imm << 2);
				end
				OP_J: begin
					writes = 1'b0;
					target = {slot[31:28], ins[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				expPc.push_back(pc);
				expNum.push_back(dst);
				expData.push_back(result);
				if (dst != '0) regs[dst] = result;
			end
			pc = npc;
			npc = target;
			steps++;
		end
	endtask

	task automatic nextRetire(output logic have, output word_t pc, output regAddr_t num,
			output word_t data);
		have = expPc.size() > 0;
		if (have) begin
			pc = expPc.pop_front();
			num = expNum.pop_front();
			data = expData.pop_front();
		end
	endtask

	task automatic nextStore(output logic have, output word_t addr, output word_t data);
		have = expStAddr.size() > 0;
		if (have) begin
			addr = expStAddr.pop_front();
			data = expStData.pop_front();
		end
	endtask

	function automatic int pending();
		return expPc.size() + expStAddr.size();
	endfunction

	initial begin
		instRdata_o = '0;
		dataRdata_o = '0;
		for (int i = 0; i < 64; i++) begin
			ram[i] = fillWord(DATA_BASE + 4 * i);
			modelRam[i] = ram[i];
		end
		buildProgram();
		runModel();
	end

	// requests are taken mid-cycle and answered just after the next edge.
	always @(negedge clk) begin
		instEnQ = instEn_i;
		instAddrQ = instAddr_i;
		dataWenQ = dataWen_i;
		dataAddrQ = dataAddr_i;
		dataWdataQ = dataWdata_i;
	end

	always @(posedge clk) begin
		#1;
		if (instEnQ) instRdata_o = romWord(instAddrQ);
		dataRdata_o = inWindow(dataAddrQ) ? ram[dataAddrQ[7:2]] : fillWord(dataAddrQ);
		if (inWindow(dataAddrQ)) begin
			for (int b = 0; b < 4; b++) begin
				if (dataWenQ[b]) ram[dataAddrQ[7:2]][8*b +: 8] = dataWdataQ[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/tbMipsCore.sv
`default_nettype none

module tbMipsCore import cpuPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam word_t RESET_PC = 32'hBFC00000;

	logic clk;
	logic arstN;
	word_t instSramRdata;
	word_t dataSramRdata;
	logic instSramEn;
	byteEn_t instSramWen;
	word_t instSramAddr;
	word_t instSramWdata;
	logic dataSramEn;
	byteEn_t dataSramWen;
	word_t dataSramAddr;
	word_t dataSramWdata;
	word_t debugWbPc;
	byteEn_t debugWbRfWen;
	regAddr_t debugWbRfWnum;
	word_t debugWbRfWdata;
	int progLen;
	int cycles = 0;
	int retired = 0;
	int stores = 0;
	int mismatches = 0;
	int failures = 0;
	logic fetchSeen = 1'b0;
	logic finished = 1'b0;

	mipsCore #(.RESET_PC(RESET_PC)) i_mipsCore (
		.clk              (clk),
		.arstN_i          (arstN),
		.instSramRdata_i  (instSramRdata),
		.dataSramRdata_i  (dataSramRdata),
		.instSramEn_o     (instSramEn),
		.instSramWen_o    (instSramWen),
		.instSramAddr_o   (instSramAddr),
		.instSramWdata_o  (instSramWdata),
		.dataSramEn_o     (dataSramEn),
		.dataSramWen_o    (dataSramWen),
		.dataSramAddr_o   (dataSramAddr),
		.dataSramWdata_o  (dataSramWdata),
		.debugWbPc_o      (debugWbPc),
		.debugWbRfWen_o   (debugWbRfWen),
		.debugWbRfWnum_o  (debugWbRfWnum),
		.debugWbRfWdata_o (debugWbRfWdata)
	);

	tbMemModel #(.RESET_PC(RESET_PC)) i_memModel (
		.clk         (clk),
		.instEn_i    (instSramEn),
		.instAddr_i  (instSramAddr),
		.instRdata_o (instSramRdata),
		.dataWen_i   (dataSramWen),
		.dataAddr_i  (dataSramAddr),
		.dataWdata_i (dataSramWdata),
		.dataRdata_o (dataSramRdata),
		.progLen_o   (progLen)
	);

	always #4 clk = ~clk;

	task automatic reportMismatch(string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		mismatches++;
	endtask

	// outputs settle well before the falling edge.
	always @(negedge clk) begin : checkOutputs
		logic have;
		word_t expPc;
		regAddr_t expNum;
		word_t expAddr;
		word_t expData;
		assert (dataSramEn == 1'b1)
			else reportMismatch("data SRAM enable is low");
		assert (instSramWen == '0 && instSramWdata == '0)
			else reportMismatch($sformatf("instruction SRAM write %b data %h",
				instSramWen, instSramWdata));
		if (!arstN) begin
			assert (debugWbRfWen == '0 && dataSramWen == '0)
				else reportMismatch("write enable active during reset");
		end else begin
			cycles++;
			assert (instSramEn == 1'b1)
				else reportMismatch("instruction SRAM enable low outside reset");
			if (!fetchSeen) begin
				fetchSeen = 1'b1;
				assert (instSramAddr == RESET_PC)
					else reportMismatch($sformatf("first fetch at %h, expected %h",
						instSramAddr, RESET_PC));
				assert (debugWbRfWen == '0 && dataSramWen == '0)
					else reportMismatch("write enable active right after reset");
			end
			if (debugWbRfWen != '0) begin
				retired++;
				assert (debugWbRfWen == 4'hF)
					else reportMismatch($sformatf("retire enable %b", debugWbRfWen));
				i_memModel.nextRetire(have, expPc, expNum, expData);
				if (!have) begin
					$display("unexpected retirement at pc %h beyond the program", debugWbPc);
					failures++;
				end else begin
					assert (debugWbPc == expPc && debugWbRfWnum == expNum
							&& debugWbRfWdata == expData)
						else reportMismatch($sformatf("retired pc %h r%0d=%h, expected pc %h r%0d=%h",
							debugWbPc, debugWbRfWnum, debugWbRfWdata, expPc, expNum, expData));
				end
			end
			if (dataSramWen != '0) begin
				stores++;
				assert (dataSramWen == 4'hF)
					else reportMismatch($sformatf("store byte enable %b", dataSramWen));
				i_memModel.nextStore(have, expAddr, expData);
				if (!have) begin
					$display("unexpected store to %h beyond the program", dataSramAddr);
					failures++;
				end else begin
					assert (dataSramAddr == expAddr && dataSramWdata == expData)
						else reportMismatch($sformatf("store %h to %h, expected %h to %h",
							dataSramWdata, dataSramAddr, expData, expAddr));
				end
			end
			finished = i_memModel.pending() == 0;
		end
	end

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		repeat (3) @(posedge clk);
		#1 arstN = 1'b1;
		// stalls at most triple the cycles per instruction.
		while (!finished && cycles < 4 * progLen + 50) @(posedge clk);
		if (!finished) begin
			$display("timeout: the program did not finish within %0d cycles", cycles);
			failures++;
		end
		$display("retired %0d, stores %0d, mismatches %0d, other errors %0d",
			retired, stores, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mipsCore.f
logic/cpuPkg.sv
logic/pipeIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
dv/tbMemModel.sv
dv/tbMipsCore.sv
